//--- Makefile
BIN  := obj_dir/Vtb_lsu
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): src.f $(SRCS)
	verilator --binary --top-module tb_lsu -f src.f -j 0

# the binary exits with a failing status on any error
run: $(BIN)
	./$(BIN)

clean:
	rm -rf obj_dir

//--- common/lsu_pkg.sv
package lsu_pkg;

  ////////////////////////////// widths
  localparam int DATA_W    = 32;           // data word
  localparam int ADDR_W    = 32;           // byte address
  localparam int NUM_BYTES = DATA_W / 8;   // byte lanes per word

  // access size, 11 decodes as a byte
  typedef enum logic [1:0] {
    SIZE_WORD = 2'b00,
    SIZE_HALF = 2'b01,
    SIZE_BYTE = 2'b10
  } lsu_size_e;

  ////////////////////////////// core side
  typedef struct packed {
    logic              we;        // store when set
    lsu_size_e         size;
    logic              sign_ext;  // loads only
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] offset;
    logic [DATA_W-1:0] wdata;     // low lanes
  } lsu_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;     // zero for stores
    logic              is_store;
  } lsu_rsp_t;

  ////////////////////////////// memory side
  typedef struct packed {
    logic [ADDR_W-1:0]    addr;
    logic                 we;
    logic [NUM_BYTES-1:0] be;
    logic [DATA_W-1:0]    wdata;   // already lane aligned
  } mem_req_t;

  // kept from grant until rvalid
  typedef struct packed {
    logic      we;
    lsu_size_e size;
    logic      sign_ext;
    logic [1:0] lane;              // addr[1:0]
  } lsu_meta_t;

endpackage

//--- hw/lsu_load_align.sv
`timescale 1ns/1ps

module lsu_load_align
(
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       rvalid_i,      // data for our access
  input  lsu_pkg::lsu_meta_t         meta_i,        // size, sign, lane
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,

  input  logic                       rsp_ready_i,
  output lsu_pkg::lsu_rsp_t          rsp_o,
  output logic                       rsp_valid_o,
  output logic                       slot_free_o    // empty or draining now
);

  import lsu_pkg::*;

  logic [DATA_W-1:0] rdata_sh;    // selected lane moved to bit 0
  logic [DATA_W-1:0] rdata_ext;   // extended result
  lsu_rsp_t          rsp_q;       // holding register
  logic              rsp_valid_q;

  ////////////////////////////// extraction
  // shift right by lane * 8
  assign rdata_sh = data_rdata_i >> {meta_i.lane, 3'b000};

  always_comb
  begin
    if (meta_i.we)
      rdata_ext = '0;                                      // stores return zero
    else
    begin
      case (meta_i.size)
        SIZE_WORD: rdata_ext = data_rdata_i;               // aligned word as is
        SIZE_HALF: rdata_ext = {{16{meta_i.sign_ext & rdata_sh[15]}}, rdata_sh[15:0]};
        default:   rdata_ext = {{24{meta_i.sign_ext & rdata_sh[7]}}, rdata_sh[7:0]};
      endcase
    end
  end

  ////////////////////////////// response hold
  // payload only, valid flag carries the state
  always_ff @(posedge clk)
  begin
    if (rvalid_i)
    begin
      rsp_q.rdata    <= rdata_ext;
      rsp_q.is_store <= meta_i.we;
    end
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      rsp_valid_q <= 1'b0;
    end
    else
    begin
      if (rvalid_i)
        rsp_valid_q <= 1'b1;            // fill one cycle after rvalid
      else if (rsp_ready_i)
        rsp_valid_q <= 1'b0;            // core took it
    end
  end

  assign rsp_o       = rsp_q;
  assign rsp_valid_o = rsp_valid_q;
  assign slot_free_o = ~rsp_valid_q | rsp_ready_i;   // lets the next grant through

endmodule

//--- hw/lsu_req_format.sv
`timescale 1ns/1ps

module lsu_req_format
(
  input  lsu_pkg::lsu_req_t req_i,   // request from the core
  output lsu_pkg::mem_req_t mem_o    // same access in bus form
);

  import lsu_pkg::*;

  logic [ADDR_W-1:0]    addr;        // base + offset
  logic [1:0]           lane;        // byte lane of the access
  logic [NUM_BYTES-1:0] be;
  logic [DATA_W-1:0]    wdata_sh;    // store data under its enables

  ////////////////////////////// address
  // always base plus offset
  assign addr = req_i.base + req_i.offset;
  assign lane = addr[1:0];

  ////////////////////////////// byte enables
  // only aligned accesses arrive here
  always_comb
  begin
    case (req_i.size)
      SIZE_WORD:
      begin
        be = 4'b1111;             // whole word
      end

      SIZE_HALF:
      begin
        if (lane[1] == 1'b1)
          be = 4'b1100;           // upper half
        else
          be = 4'b0011;           // lower half
      end

      default:
      begin
        // byte, also covers 2'b11
        case (lane)
          2'b00:   be = 4'b0001;
          2'b01:   be = 4'b0010;
          2'b10:   be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
    endcase
  end

  ////////////////////////////// store data
  // register holds the value in the low lanes
  // shift it up by lane * 8 so it sits under be
  always_comb
  begin
    case (lane)
      2'b00:   wdata_sh = req_i.wdata;
      2'b01:   wdata_sh = {req_i.wdata[23:0], 8'h00};
      2'b10:   wdata_sh = {req_i.wdata[15:0], 16'h0000};
      default: wdata_sh = {req_i.wdata[7:0], 24'h00_0000};
    endcase
  end

  // pack for the controller
  always_comb
  begin
    mem_o       = '0;
    mem_o.addr  = addr;
    mem_o.we    = req_i.we;
    mem_o.be    = be;
    mem_o.wdata = wdata_sh;   // don't care on loads
  end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
(
  input  logic                    clk,
  input  logic                    rst_n,

  // core request
  input  lsu_pkg::lsu_req_t       req_i,
  input  logic                    req_valid_i,
  output logic                    req_ready_o,

  // memory bus
  output logic                    data_req_o,
  output lsu_pkg::mem_req_t       mem_o,
  input  logic                    data_gnt_i,
  input  logic                    data_rvalid_i,
  input  logic [lsu_pkg::DATA_W-1:0] data_rdata_i,

  // core response
  output lsu_pkg::lsu_rsp_t       rsp_o,
  output logic                    rsp_valid_o,
  input  logic                    rsp_ready_i
);

  import lsu_pkg::*;

  mem_req_t  fmt_req;    // formatted access, not yet on the bus
  lsu_meta_t meta;       // captured at grant
  logic      rvalid;     // rvalid for our outstanding access
  logic      slot_free;  // response register can take a result

  // address, byte enables and store lanes
  lsu_req_format i_req_format (
    .req_i ( req_i   ),
    .mem_o ( fmt_req )
  );

  // bus handshake, one access in flight
  lsu_txn_ctrl i_txn_ctrl (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .req_valid_i   ( req_valid_i   ),
    .req_i         ( req_i         ),
    .fmt_i         ( fmt_req       ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .slot_free_i   ( slot_free     ),
    .req_ready_o   ( req_ready_o   ),
    .data_req_o    ( data_req_o    ),
    .mem_o         ( mem_o         ),
    .meta_o        ( meta          ),
    .rvalid_o      ( rvalid        )
  );

  // extraction, extension and response hold
  lsu_load_align i_load_align (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .rvalid_i     ( rvalid       ),
    .meta_i       ( meta         ),
    .data_rdata_i ( data_rdata_i ),
    .rsp_ready_i  ( rsp_ready_i  ),
    .rsp_o        ( rsp_o        ),
    .rsp_valid_o  ( rsp_valid_o  ),
    .slot_free_o  ( slot_free    )
  );

endmodule

//--- hw/lsu_txn_ctrl.sv
`timescale 1ns/1ps

module lsu_txn_ctrl
(
  input  logic               clk,
  input  logic               rst_n,

  input  logic               req_valid_i,   // core has an access
  input  lsu_pkg::lsu_req_t  req_i,         // raw request, for metadata
  input  lsu_pkg::mem_req_t  fmt_i,         // formatted access

  input  logic               data_gnt_i,
  input  logic               data_rvalid_i,
  input  logic               slot_free_i,   // response side can take a result

  output logic               req_ready_o,   // high exactly at grant
  output logic               data_req_o,
  output lsu_pkg::mem_req_t  mem_o,
  output lsu_pkg::lsu_meta_t meta_o,        // load info for the aligner
  output logic               rvalid_o       // rvalid of our access
);

  import lsu_pkg::*;

  logic      outstanding_q;  // one access waiting for rvalid
  logic      grant;          // request accepted this cycle
  lsu_meta_t meta_q;

  ////////////////////////////// issue
  // only one access at a time, and only if the result has somewhere to go
  assign data_req_o  = req_valid_i & ~outstanding_q & slot_free_i;
  assign grant       = data_req_o & data_gnt_i;
  assign req_ready_o = grant;        // core transfer == bus grant

  assign mem_o = fmt_i;               // bus sees the formatted access as is

  ////////////////////////////// outstanding flag
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (rst_n == 1'b0)
    begin
      outstanding_q <= 1'b0;
    end
    else
    begin
      if (grant)
        outstanding_q <= 1'b1;        // set the edge after grant
      else if (data_rvalid_i)
        outstanding_q <= 1'b0;        // clear the edge after rvalid
    end
  end

  ////////////////////////////// metadata
  // sampled at grant and held until the data comes back
  always_ff @(posedge clk)
  begin
    if (grant)
    begin
      meta_q.we       <= req_i.we;
      meta_q.size     <= req_i.size;
      meta_q.sign_ext <= req_i.sign_ext;
      meta_q.lane     <= fmt_i.addr[1:0];  // lane of the final address
    end
  end

  assign meta_o   = meta_q;
  assign rvalid_o = data_rvalid_i & outstanding_q;  // ignore stray rvalid

endmodule

//--- src.f
common/lsu_pkg.sv
hw/lsu_req_format.sv
hw/lsu_txn_ctrl.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
test/tb_lsu.sv

//--- test/lsu_vectors.txt
// columns: we size sign_ext base offset wdata expected_rdata, all hex
// size 0 word, 1 half, 2 byte, 3 byte; memory bytes start out equal to their address
0 0 0 00000010 00000000 00000000 13121110
0 2 0 00000020 00000005 00000000 00000025
0 1 0 00000030 0000000A 00000000 00003B3A
1 0 0 00000000 00000008 89ABCDEF 00000000
0 0 0 00000008 00000000 00000000 89ABCDEF
0 2 1 00000008 00000003 00000000 FFFFFF89
0 2 0 00000008 00000003 00000000 00000089
0 1 1 00000008 00000002 00000000 FFFF89AB
0 1 0 00000008 00000000 00000000 0000CDEF
0 1 1 00000008 00000000 00000000 FFFFCDEF
0 2 1 00000008 00000001 00000000 FFFFFFCD
1 2 0 0000000C 00000001 1234565A 00000000
1 1 0 00000010 FFFFFFFE DEAD80F1 00000000
0 0 0 0000000C 00000000 00000000 80F15A0C
0 1 1 0000000C 00000002 00000000 FFFF80F1
0 2 1 0000000C 00000003 00000000 FFFFFF80
0 2 0 0000000C 00000001 00000000 0000005A
1 2 0 0000003C 00000000 AAAAAAFF 00000000
1 1 0 00000000 00000000 55557FFE 00000000
0 0 0 0000003C 00000000 00000000 3F3E3DFF
0 0 0 00000000 00000000 00000000 03027FFE
0 1 1 00000000 00000000 00000000 00007FFE
0 3 1 00000038 00000004 00000000 FFFFFFFF

//--- test/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;

  import lsu_pkg::*;

  localparam int NUM_VEC  = 23;   // lines in the vector file
  localparam int VEC_COLS = 7;    // we size sign_ext base offset wdata rdata

  logic              clk = 1'b0;
  logic              rst_n;
  lsu_req_t          req_i;
  logic              req_valid_i;
  logic              req_ready_o;
  logic              data_req_o;
  mem_req_t          mem_o;
  logic              data_gnt_i;
  logic              data_rvalid_i;
  logic [DATA_W-1:0] data_rdata_i;
  lsu_rsp_t          rsp_o;
  logic              rsp_valid_o;
  logic              rsp_ready_i;

  logic [31:0] vec [0:NUM_VEC*VEC_COLS-1];  // flat vector table
  logic [31:0] mem [0:15];                  // memory model, word = addr[5:2]
  logic [31:0] rd_word;                     // load data waiting for rvalid
  int          seed     = 62;
  int          gnt_idx  = 0;                // next vector expected at the bus
  int          rsp_idx  = 0;                // next vector expected at the core
  int          gnt_wait = 1;                // cycles until grant
  int          rv_wait  = 0;                // cycles until rvalid

  lsu_top i_dut (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .req_i         ( req_i         ),
    .req_valid_i   ( req_valid_i   ),
    .req_ready_o   ( req_ready_o   ),
    .data_req_o    ( data_req_o    ),
    .mem_o         ( mem_o         ),
    .data_gnt_i    ( data_gnt_i    ),
    .data_rvalid_i ( data_rvalid_i ),
    .data_rdata_i  ( data_rdata_i  ),
    .rsp_o         ( rsp_o         ),
    .rsp_valid_o   ( rsp_valid_o   ),
    .rsp_ready_i   ( rsp_ready_i   )
  );

  always #50 clk = ~clk;   // 100 ns period

  ////////////////////////////// helpers
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual)
    begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("TEST FAIL");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  // nothing may move while idle
  task automatic check_idle(input string name);
    check_value({name, " data_req_o"}, 0, 32'(data_req_o));
    check_value({name, " req_ready_o"}, 0, 32'(req_ready_o));
    check_value({name, " rsp_valid_o"}, 0, 32'(rsp_valid_o));
  endtask

  function automatic lsu_req_t build_req(int v);
    lsu_req_t r;
    int       b;
    b          = v * VEC_COLS;
    r.we       = vec[b][0];
    r.size     = lsu_size_e'(vec[b+1][1:0]);
    r.sign_ext = vec[b+2][0];
    r.base     = vec[b+3];
    r.offset   = vec[b+4];
    r.wdata    = vec[b+5];
    return r;
  endfunction

  // lanes enabled by an aligned access of this size
  function automatic logic [3:0] expected_be(logic [1:0] size, logic [1:0] lane);
    logic [3:0] be;
    if (size == 2'b00)
      be = 4'b1111;
    else if (size == 2'b01)
      be = lane[1] ? 4'b1100 : 4'b0011;
    else
      be = 4'b0001 << lane;   // byte, 11 included
    return be;
  endfunction

  ////////////////////////////// memory model
  task automatic serve_memory();
    int          b;
    logic [31:0] exp_addr;
    b             = gnt_idx * VEC_COLS;
    exp_addr      = vec[b+3] + vec[b+4];
    data_rvalid_i <= 1'b0;
    if (data_req_o && data_gnt_i)
    begin
      check_value($sformatf("vec %0d addr", gnt_idx), exp_addr, mem_o.addr);
      check_value($sformatf("vec %0d be", gnt_idx),
                  32'(expected_be(vec[b+1][1:0], exp_addr[1:0])), 32'(mem_o.be));
      check_value($sformatf("vec %0d we", gnt_idx), 32'(vec[b][0]), 32'(mem_o.we));
      check_value($sformatf("vec %0d grant with response held", gnt_idx), 0,
                  32'(rsp_valid_o & ~rsp_ready_i));
      rd_word = mem[mem_o.addr[5:2]];   // old word, stores ignore it
      if (mem_o.we)
        for (int l = 0; l < NUM_BYTES; l++)
          if (mem_o.be[l])
            mem[mem_o.addr[5:2]][8*l +: 8] = mem_o.wdata[8*l +: 8];
      gnt_idx++;
      rv_wait    = 1 + $unsigned($random(seed)) % 3;   // 1..3 after grant
      gnt_wait   = $unsigned($random(seed)) % 3;       // 0..2 for the next one
      data_gnt_i <= (gnt_wait == 0);
    end
    else if (data_req_o && !data_gnt_i)
    begin
      if (gnt_wait > 0)
        gnt_wait--;
      if (gnt_wait == 0)
        data_gnt_i <= 1'b1;
    end
    if (rv_wait > 0)
    begin
      rv_wait--;
      if (rv_wait == 0)
      begin
        data_rvalid_i <= 1'b1;    // single cycle pulse
        data_rdata_i  <= rd_word;
      end
    end
  endtask

  ////////////////////////////// response side
  task automatic take_response();
    int b;
    b = rsp_idx * VEC_COLS;
    if (rsp_valid_o && rsp_ready_i)
    begin
      check_value("response count beyond last vector", 0, 32'(rsp_idx >= NUM_VEC));
      check_value($sformatf("vec %0d rdata", rsp_idx), vec[b+6], rsp_o.rdata);
      check_value($sformatf("vec %0d is_store", rsp_idx), 32'(vec[b][0]),
                  32'(rsp_o.is_store));
      rsp_idx++;
    end
    rsp_ready_i <= ($unsigned($random(seed)) % 4) != 0;   // ready 3 of 4 cycles
  endtask

  initial
  begin
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= 1'b0;
    data_rdata_i  <= '0;
    rsp_ready_i   <= 1'b0;
    for (int w = 0; w < 16; w++)
      mem[w] = {8'(4*w+3), 8'(4*w+2), 8'(4*w+1), 8'(4*w)};   // each byte = its address
    forever
    begin
      @(posedge clk);
      serve_memory();
      take_response();
    end
  end

  ////////////////////////////// stimulus
  initial
  begin
    rst_n       <= 1'b0;
    req_i       <= '0;
    req_valid_i <= 1'b0;
    $readmemh("test/lsu_vectors.txt", vec);
    repeat (5)
    begin
      @(posedge clk);
      check_idle("reset");
    end
    rst_n <= 1'b1;
    @(posedge clk);
    check_idle("first cycle after reset");

    for (int v = 0; v < NUM_VEC; v++)
    begin
      req_i       <= build_req(v);
      req_valid_i <= 1'b1;
      @(posedge clk);
      while (req_ready_o !== 1'b1)   // held until the grant
        @(posedge clk);
    end
    req_valid_i <= 1'b0;

    while (rsp_idx < NUM_VEC)
      @(posedge clk);
    repeat (2) @(posedge clk);
    check_value("grant count", NUM_VEC, gnt_idx);
    check_value("response after last vector", 0, 32'(rsp_valid_o));
    $display("TEST PASS");
    $finish;
  end

  // 20 cycles per vector, plus reset
  initial
  begin
    #((NUM_VEC * 20 + 5) * 100);
    $display("run hung, not every vector got its response in time");
    $display("TEST FAIL");
    $fatal(1, "watchdog timeout");
  end

endmodule
